/* test/fifo_input.txt */
// columns, all hex: w_en w_data r_en exp_byte exp_level
// exp_byte and exp_level are seen one cycle after the line; exp_byte unused without a read
0 00000000 0 00 00
1 44332211 0 00 04
1 88776655 0 00 08
0 00000000 1 11 07
0 00000000 1 22 06
0 00000000 1 33 05
0 00000000 1 44 04
0 00000000 1 55 03
0 00000000 1 66 02
0 00000000 1 77 01
0 00000000 1 88 00
0 00000000 1 00 00
1 03020100 0 00 04
1 13121110 0 00 08
1 23222120 0 00 0c
1 33323130 0 00 10
1 43424140 0 00 14
1 53525150 0 00 18
1 63626160 0 00 1c
1 73727170 0 00 20
1 83828180 0 00 24
1 93929190 0 00 28
1 a3a2a1a0 0 00 2c
1 b3b2b1b0 0 00 30
1 c3c2c1c0 0 00 34
1 d3d2d1d0 0 00 38
1 e3e2e1e0 0 00 3c
1 f3f2f1f0 0 00 40
1 deadbeef 0 00 40
0 00000000 1 00 3f
0 00000000 1 01 3e
0 00000000 1 02 3d
0 00000000 1 03 3c
0 00000000 1 10 3b
0 00000000 1 11 3a
0 00000000 1 12 39
0 00000000 1 13 38
0 00000000 1 20 37
0 00000000 1 21 36
0 00000000 1 22 35
0 00000000 1 23 34
0 00000000 1 30 33
0 00000000 1 31 32
0 00000000 1 32 31
0 00000000 1 33 30
1 07060504 1 40 33
1 17161514 1 41 36
1 27262524 1 42 39
1 37363534 1 43 3c
1 47464544 1 50 3f
0 00000000 1 51 3e
0 00000000 1 52 3d
0 00000000 1 53 3c
0 00000000 1 60 3b
0 00000000 1 61 3a
0 00000000 1 62 39
0 00000000 1 63 38
0 00000000 1 70 37
0 00000000 1 71 36
0 00000000 1 72 35
0 00000000 1 73 34
0 00000000 1 80 33
0 00000000 1 81 32
0 00000000 1 82 31
0 00000000 1 83 30
0 00000000 1 90 2f
0 00000000 1 91 2e
0 00000000 1 92 2d
0 00000000 1 93 2c
0 00000000 1 a0 2b
0 00000000 1 a1 2a
0 00000000 1 a2 29
0 00000000 1 a3 28
0 00000000 1 b0 27
0 00000000 1 b1 26
0 00000000 1 b2 25
0 00000000 1 b3 24
0 00000000 1 c0 23
0 00000000 1 c1 22
0 00000000 1 c2 21
0 00000000 1 c3 20
0 00000000 1 d0 1f
0 00000000 1 d1 1e
0 00000000 1 d2 1d
0 00000000 1 d3 1c
0 00000000 1 e0 1b
0 00000000 1 e1 1a
0 00000000 1 e2 19
0 00000000 1 e3 18

/* sim.f */
source/fifo_pkg.sv
source/fifo_ram_2p.sv
source/fifo_ctrl.sv
source/fifo_asym_conv.sv
source/fifo_top.sv
test/fifo_checker.sv
test/tb_fifo_top.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the fifo_top testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_fifo_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_fifo_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* test/tb_fifo_top.sv */
/* testbench for fifo_top, replays test/fifo_input.txt one line per clock
   run from the project root so the data file path resolves
*/
`timescale 1ns/100ps
`default_nettype none

module tb_fifo_top
   import fifo_pkg::*;
();

   localparam int FIELDS    = 5;    // columns per data line
   localparam int MAX_LINES = 256;
   localparam int GAP_MAX   = 2;    // idle cycles before a section, at most
   localparam int N_GAPS    = 3;
   localparam int MARGIN    = 20;
   localparam logic [31:0] NO_ENTRY = 32'hffff_ffff;

   // one data file line, strobes plus what they should produce
   typedef struct packed {
      logic                w_en;
      logic [W_DATA_W-1:0] w_data;
      logic                r_en;
      logic [R_DATA_W-1:0] exp_byte;
      logic [LEVEL_W-1:0]  exp_level;
   } stim_t;

   logic                clk;
   logic                rst;
   stim_t               cur;
   logic [R_DATA_W-1:0] r_data;
   logic                r_valid;
   logic                w_full;
   logic                r_empty;
   logic [LEVEL_W-1:0]  level;

   logic [31:0] vec [MAX_LINES*FIELDS];
   int          n_lines;
   int          cycles;
   int          limit;
   int          checks;
   int          errors;

   fifo_top i_fifo_top (
      .clk_i     (clk),
      .rst_i     (rst),
      .w_en_i    (cur.w_en),
      .w_data_i  (cur.w_data),
      .r_en_i    (cur.r_en),
      .r_data_o  (r_data),
      .r_valid_o (r_valid),
      .w_full_o  (w_full),
      .r_empty_o (r_empty),
      .level_o   (level)
   );

   fifo_checker i_fifo_checker (
      .clk_i       (clk),
      .rst_i       (rst),
      .r_en_i      (cur.r_en),
      .exp_byte_i  (cur.exp_byte),
      .exp_level_i (cur.exp_level),
      .r_data_i    (r_data),
      .r_valid_i   (r_valid),
      .w_full_i    (w_full),
      .r_empty_i   (r_empty),
      .level_i     (level),
      .checks_o    (checks),
      .errors_o    (errors)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // run length bound, counted from time zero
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: stimulus not finished after %0d cycles", cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   function automatic stim_t line_at(int idx);
      stim_t s;
      s.w_en      = vec[idx*FIELDS][0];
      s.w_data    = vec[idx*FIELDS+1];
      s.r_en      = vec[idx*FIELDS+2][0];
      s.exp_byte  = vec[idx*FIELDS+3][R_DATA_W-1:0];
      s.exp_level = vec[idx*FIELDS+4][LEVEL_W-1:0];
      return s;
   endfunction

   // read-empty, fill and drain sections of the data file
   function automatic bit starts_section(int idx);
      return idx == 11 || idx == 12 || idx == 29;
   endfunction

   // strobes low, expected level carried over
   task automatic idle_gap();
      int n;
      n = $urandom_range(GAP_MAX, 0);
      repeat (n) begin
         @(posedge clk);
         cur.w_en <= 1'b0;
         cur.r_en <= 1'b0;
      end
   endtask

   initial begin
      cur  = '0;
      rst  = 1'b1;
      void'($urandom(60));
      for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
         vec[i] = NO_ENTRY;
      end
      $readmemh("test/fifo_input.txt", vec);
      n_lines = 0;
      while (n_lines < MAX_LINES && vec[n_lines*FIELDS] != NO_ENTRY) begin
         n_lines++;
      end
      limit = n_lines + N_GAPS*GAP_MAX + MARGIN;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < n_lines; i++) begin
         if (starts_section(i)) begin
            idle_gap();
         end
         @(posedge clk);
         cur <= line_at(i);
      end
      @(posedge clk);
      cur.w_en <= 1'b0;
      cur.r_en <= 1'b0;
      repeat (2) @(posedge clk);  // last line compared by now
      @(negedge clk);
      if (n_lines == 0) begin
         $display("no stimulus lines found in test/fifo_input.txt");
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0 && checks > 0 && n_lines > 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/fifo_checker.sv */
/* compares fifo_top outputs with the expected byte and level of each line,
   one cycle after the line is driven; flags follow from the expected level
*/
`timescale 1ns/100ps
`default_nettype none

module fifo_checker
   import fifo_pkg::*;
(
   input  wire logic                clk_i,
   input  wire logic                rst_i,

   // strobe and expected values as driven this cycle
   input  wire logic                r_en_i,
   input  wire logic [R_DATA_W-1:0] exp_byte_i,
   input  wire logic [LEVEL_W-1:0]  exp_level_i,

   // DUT outputs
   input  wire logic [R_DATA_W-1:0] r_data_i,
   input  wire logic                r_valid_i,
   input  wire logic                w_full_i,
   input  wire logic                r_empty_i,
   input  wire logic [LEVEL_W-1:0]  level_i,

   output int                       checks_o,
   output int                       errors_o
);

   typedef struct packed {
      logic                armed;
      logic                valid;
      logic [R_DATA_W-1:0] data;
      logic [LEVEL_W-1:0]  level;
   } expect_t;

   expect_t pend;  // line from last cycle, due now

   task automatic compare(string what, int got, int want);
      if (got != want) begin
         $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
         errors_o++;
      end
   endtask

   always @(posedge clk_i) begin
      if (rst_i) begin
         pend     = '0;
         checks_o = 0;
         errors_o = 0;
      end else begin
         if (pend.armed) begin
            checks_o++;
            compare("level_o", int'(level_i), int'(pend.level));
            compare("r_empty_o", int'(r_empty_i), int'(pend.level == '0));
            compare("w_full_o", int'(w_full_i), int'(int'(pend.level) > FIFO_BYTES - LANES));
            compare("r_valid_o", int'(r_valid_i), int'(pend.valid));
            if (pend.valid) begin
               compare("r_data_o", int'(r_data_i), int'(pend.data));
            end
         end
         // a read only counts when the level before it was not zero
         pend.valid = r_en_i && pend.level != '0;
         pend.armed = 1'b1;
         pend.data  = exp_byte_i;
         pend.level = exp_level_i;
      end
   end

endmodule

`default_nettype wire

/* source/fifo_top.sv */
/* synchronous FIFO, 32-bit words in, 8-bit bytes out, 64 bytes deep
   strobes are single cycle; watch w_full_o and r_empty_o before strobing
*/
`timescale 1ns/100ps
`default_nettype none

module fifo_top
   import fifo_pkg::*;
(
   input  wire logic                clk_i,
   input  wire logic                rst_i,

   // write port
   input  wire logic                w_en_i,
   input  wire logic [W_DATA_W-1:0] w_data_i,

   // read port
   input  wire logic                r_en_i,
   output logic      [R_DATA_W-1:0] r_data_o,
   output logic                     r_valid_o,

   // status
   output logic                     w_full_o,
   output logic                     r_empty_o,
   output logic      [LEVEL_W-1:0]  level_o
);

   logic                  w_accept;
   logic                  r_accept;
   logic [MEM_ADDR_W-1:0] w_addr;   // word address
   logic [ADDR_W-1:0]     r_addr;   // byte address
   mem_wr_t               mem_wr;
   mem_rd_t               mem_rd;
   logic [W_DATA_W-1:0]   mem_rdata;

   fifo_ctrl i_fifo_ctrl (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .w_en_i     (w_en_i),
      .r_en_i     (r_en_i),
      .w_accept_o (w_accept),
      .r_accept_o (r_accept),
      .w_addr_o   (w_addr),
      .r_addr_o   (r_addr),
      .level_o    (level_o),
      .w_full_o   (w_full_o),
      .r_empty_o  (r_empty_o)
   );

   fifo_asym_conv i_fifo_asym_conv (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .w_accept_i  (w_accept),
      .w_addr_i    (w_addr),
      .w_data_i    (w_data_i),
      .r_accept_i  (r_accept),
      .r_addr_i    (r_addr),
      .mem_wr_o    (mem_wr),
      .mem_rd_o    (mem_rd),
      .mem_rdata_i (mem_rdata),
      .r_data_o    (r_data_o),
      .r_valid_o   (r_valid_o)
   );

   // one word per entry, 16 entries
   fifo_ram_2p #(
      .DATA_W (W_DATA_W),
      .ADDR_W (MEM_ADDR_W)
   ) i_fifo_ram_2p (
      .clk_i    (clk_i),
      .mem_wr_i (mem_wr),
      .mem_rd_i (mem_rd),
      .rdata_o  (mem_rdata)
   );

endmodule

`default_nettype wire

/* source/fifo_asym_conv.sv */
/* maps the word write and byte read addresses onto the wide memory
   byte lane comes out one cycle after the accepted read, lsb lane first
*/
`timescale 1ns/100ps
`default_nettype none

module fifo_asym_conv
   import fifo_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,

   // write side from the controller
   input  wire logic                  w_accept_i,
   input  wire logic [MEM_ADDR_W-1:0] w_addr_i,
   input  wire logic [W_DATA_W-1:0]   w_data_i,

   // read side from the controller
   input  wire logic                  r_accept_i,
   input  wire logic [ADDR_W-1:0]     r_addr_i,

   // memory ports
   output mem_wr_t                    mem_wr_o,
   output mem_rd_t                    mem_rd_o,
   input  wire logic [W_DATA_W-1:0]   mem_rdata_i,

   // byte output
   output logic      [R_DATA_W-1:0]   r_data_o,
   output logic                       r_valid_o
);

   logic [LANE_W-1:0]                lane_q;  // lane of the byte in flight
   logic [LANES-1:0][R_DATA_W-1:0]   rd_lanes;

   // write goes straight through as one word
   always_comb begin
      mem_wr_o.en   = w_accept_i;
      mem_wr_o.addr = w_addr_i;
      mem_wr_o.data = w_data_i;
   end

   // upper byte address bits select the word
   always_comb begin
      mem_rd_o.en   = r_accept_i;
      mem_rd_o.addr = r_addr_i[ADDR_W-1:LANE_W];
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         r_valid_o <= 1'b0;
      end else begin
         r_valid_o <= r_accept_i;
      end
   end

   // lane tracks the memory read, same edge
   always_ff @(posedge clk_i) begin
      if (r_accept_i) begin
         lane_q <= r_addr_i[LANE_W-1:0];
      end
   end

   // lane 0 is the least significant byte
   assign rd_lanes = mem_rdata_i;
   assign r_data_o = rd_lanes[lane_q];

   // every accepted read yields a valid byte on the next edge
   a_valid_after_read: assert property (
      @(posedge clk_i) disable iff (rst_i)
      r_accept_i |=> r_valid_o
   ) else $error("accepted read gave no valid byte");

endmodule

`default_nettype wire

/* source/fifo_ctrl.sv */
/* address counters, byte level and registered full/empty flags
   strobes against a full or empty FIFO are dropped, no back-pressure
*/
`timescale 1ns/100ps
`default_nettype none

module fifo_ctrl
   import fifo_pkg::*;
(
   input  wire logic                  clk_i,
   input  wire logic                  rst_i,

   // raw strobes from the user side
   input  wire logic                  w_en_i,
   input  wire logic                  r_en_i,

   // qualified strobes and addresses to the converter
   output logic                       w_accept_o,
   output logic                       r_accept_o,
   output logic      [MEM_ADDR_W-1:0] w_addr_o,
   output logic      [ADDR_W-1:0]     r_addr_o,

   // status
   output logic      [LEVEL_W-1:0]    level_o,
   output logic                       w_full_o,
   output logic                       r_empty_o
);

   logic [LEVEL_W-1:0] level_nxt;
   logic               full_nxt;
   logic               empty_nxt;

   // a strobe only counts when the matching flag allows it
   assign w_accept_o = w_en_i & ~w_full_o;
   assign r_accept_o = r_en_i & ~r_empty_o;

   // word and byte addresses, wrapping at their widths
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_addr_o <= '0;
         r_addr_o <= '0;
      end else begin
         if (w_accept_o) begin
            w_addr_o <= w_addr_o + 1'b1;  // one word per write
         end
         if (r_accept_o) begin
            r_addr_o <= r_addr_o + 1'b1;  // one byte per read
         end
      end
   end

   // next level in bytes
   always_comb begin
      level_nxt = level_o;
      case ({w_accept_o, r_accept_o})
         2'b10: begin
            level_nxt = level_o + LEVEL_W_INC;  // write only
         end
         2'b01: begin
            level_nxt = level_o - LEVEL_R_INC;  // read only
         end
         2'b11: begin
            level_nxt = level_o + LEVEL_W_INC - LEVEL_R_INC;
         end
         default: begin
            level_nxt = level_o;
         end
      endcase
   end

   // full once another word would no longer fit
   assign full_nxt  = level_nxt > FULL_LEVEL;
   assign empty_nxt = level_nxt < LEVEL_R_INC;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         level_o   <= '0;
         w_full_o  <= 1'b0;
         r_empty_o <= 1'b1;
      end else begin
         level_o   <= level_nxt;
         w_full_o  <= full_nxt;
         r_empty_o <= empty_nxt;
      end
   end

   // level stays within capacity over any strobe sequence
   a_level_max: assert property (
      @(posedge clk_i) disable iff (rst_i)
      level_o <= LEVEL_W'(FIFO_BYTES)
   ) else $error("fifo level %0d above capacity", level_o);

   a_flags_excl: assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(w_full_o && r_empty_o)
   ) else $error("full and empty both set");

endmodule

`default_nettype wire

/* source/fifo_ram_2p.sv */
/* simple two-port RAM, one clock, registered read
   a read of the word being written returns the old data
   port vectors use the en/addr/data layout of the package memory structs
*/
`timescale 1ns/100ps
`default_nettype none

module fifo_ram_2p #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 4
) (
   input  wire logic                     clk_i,
   input  wire logic [ADDR_W+DATA_W:0]   mem_wr_i,  // {en, addr, data}
   input  wire logic [ADDR_W:0]          mem_rd_i,  // {en, addr}
   output logic      [DATA_W-1:0]        rdata_o
);

   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } wr_port_t;

   typedef struct packed {
      logic              en;
      logic [ADDR_W-1:0] addr;
   } rd_port_t;

   wr_port_t          wr;
   rd_port_t          rd;
   logic [DATA_W-1:0] mem [2**ADDR_W];

   assign wr = mem_wr_i;
   assign rd = mem_rd_i;

   always_ff @(posedge clk_i) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // output holds while no read is requested
   always_ff @(posedge clk_i) begin
      if (rd.en) begin
         rdata_o <= mem[rd.addr];
      end
   end

endmodule

`default_nettype wire

/* source/fifo_pkg.sv */
/* shared widths and memory port structs for the 32-bit in, 8-bit out FIFO
   only the wide-write / narrow-read ratio is supported, fixed here
*/
`default_nettype none

package fifo_pkg;

   // data widths
   localparam int W_DATA_W = 32;  // write word
   localparam int R_DATA_W = 8;   // read byte

   // byte lanes per word
   localparam int LANES  = W_DATA_W / R_DATA_W;
   localparam int LANE_W = $clog2(LANES);

   // address spaces
   localparam int ADDR_W     = 6;                // byte address
   localparam int MEM_ADDR_W = ADDR_W - LANE_W;  // word address

   // capacity and level
   localparam int FIFO_BYTES = 2 ** ADDR_W;
   localparam int LEVEL_W    = ADDR_W + 1;  // holds 0 up to FIFO_BYTES

   // level steps, sized to the level register
   localparam logic [LEVEL_W-1:0] LEVEL_W_INC = LEVEL_W'(LANES);  // one word in
   localparam logic [LEVEL_W-1:0] LEVEL_R_INC = LEVEL_W'(1);      // one byte out
   localparam logic [LEVEL_W-1:0] FULL_LEVEL  = LEVEL_W'(FIFO_BYTES - LANES);

   // memory write port, field order en/addr/data from msb down
   typedef struct packed {
      logic                  en;
      logic [MEM_ADDR_W-1:0] addr;
      logic [W_DATA_W-1:0]   data;
   } mem_wr_t;

   // memory read port
   typedef struct packed {
      logic                  en;
      logic [MEM_ADDR_W-1:0] addr;
   } mem_rd_t;

endpackage

`default_nettype wire
